//--- Bender.yml
package:
  name: imuldiv

sources:
  - files:
      - common/imuldiv_pkg.sv
      - int_div/int_div_dpath.sv
      - int_div/int_div_ctrl.sv
      - int_div/int_div_iterative.sv
      - rtl/int_mul_iterative.sv
      - rtl/imuldiv_unit.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/imuldiv_tb.sv

//--- common/imuldiv_pkg.sv
// ------------------------------------------------------------
// shared types for the iterative multiply/divide unit
// operands are fixed at xlen bits and results at 2*xlen bits
// ------------------------------------------------------------

`default_nettype none

package imuldiv_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------

  // operand width
  localparam int xlen = 32;

  // iteration counter, counts xlen-1 down to 0
  localparam int count_w = 5;

  // ------------------------------------------------------------
  // operation encoding
  // ------------------------------------------------------------

  typedef enum logic [1:0] {
    // signed product
    op_mul  = 2'd0,
    // unsigned product
    op_mulu = 2'd1,
    // signed quotient and remainder
    op_div  = 2'd2,
    // unsigned quotient and remainder
    op_divu = 2'd3
  } imuldiv_op_e;

  // ------------------------------------------------------------
  // messages
  // ------------------------------------------------------------

  // request, 66 bits
  typedef struct packed {
    imuldiv_op_e     op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
  } imuldiv_req_t;

  // response, 64 bits
  // divide: remainder in the upper half, quotient in the lower half
  // multiply: full product
  typedef struct packed {
    logic [2*xlen-1:0] result;
  } imuldiv_resp_t;

  // ------------------------------------------------------------
  // decode helpers
  // ------------------------------------------------------------

  // signed variants of both units
  function automatic logic is_signed_op(imuldiv_op_e op);
    return (op == op_mul) || (op == op_div);
  endfunction

  // steers a request to the divider
  function automatic logic is_div_op(imuldiv_op_e op);
    return (op == op_div) || (op == op_divu);
  endfunction

endpackage

`default_nettype wire

//--- int_div/int_div_ctrl.sv
// ------------------------------------------------------------
// divider FSM, idle -> calc (32 steps) -> done
// one operation at a time, held in done until resp_rdy
// ------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module int_div_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  imuldiv_pkg::imuldiv_op_e op,
  input  logic                     req_val,
  output logic                     req_rdy,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  input  logic                     sub_neg,
  input  logic                     count_zero,
  output logic                     load,
  output logic                     step,
  output logic                     signed_op,
  output logic                     fix_signs
);

  import imuldiv_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_e;

  state_e state_q;
  logic   signed_q;

  // ------------------------------------------------------------
  // state register
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q  <= st_idle;
      signed_q <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (req_val) begin
            state_q  <= st_calc;
            signed_q <= is_signed_op(op);
          end
        end
        st_calc: begin
          // last step happens with the counter at zero
          if (count_zero) begin
            state_q <= st_done;
          end
        end
        st_done: begin
          if (resp_rdy) begin
            state_q <= st_idle;
          end
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // outputs, decoded from state
  // ------------------------------------------------------------

  assign req_rdy   = (state_q == st_idle);
  assign resp_val  = (state_q == st_done);
  assign load      = req_rdy && req_val;
  assign step      = (state_q == st_calc);
  assign fix_signs = (state_q == st_done);

  // live decode while loading, held flag afterwards
  assign signed_op = req_rdy ? is_signed_op(op) : signed_q;

  // datapath counter ends calc exactly xlen steps after the load
  assert property (@(posedge clk) disable iff (reset)
    load |-> ##xlen (step && count_zero));

  // datapath compare is always resolved while stepping
  assert property (@(posedge clk) disable iff (reset)
    step |-> !$isunknown(sub_neg));

endmodule

`default_nettype wire

//--- int_div/int_div_dpath.sv
// ------------------------------------------------------------
// restoring divider datapath, one quotient bit per step
// divide by zero yields all ones quotient and remainder a
// ------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module int_div_dpath (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_pkg::imuldiv_req_t  req,
  output imuldiv_pkg::imuldiv_resp_t result,
  input  logic                       load,
  input  logic                       step,
  input  logic                       signed_op,
  input  logic                       fix_signs,
  output logic                       sub_neg,
  output logic                       count_zero
);

  import imuldiv_pkg::*;

  // ------------------------------------------------------------
  // operand magnitudes
  // ------------------------------------------------------------

  // sign bits only count for signed ops
  logic            a_neg;
  logic            b_neg;
  logic [xlen-1:0] a_mag;
  logic [xlen-1:0] b_mag;

  assign a_neg = signed_op && req.a[xlen-1];
  assign b_neg = signed_op && req.b[xlen-1];
  assign a_mag = a_neg ? (~req.a + 1'b1) : req.a;
  assign b_mag = b_neg ? (~req.b + 1'b1) : req.b;

  // ------------------------------------------------------------
  // shift and subtract
  // ------------------------------------------------------------

  // remainder in [2*xlen:xlen], quotient in [xlen-1:0]
  logic [2*xlen:0]    rq_q;
  // divisor aligned to the remainder half
  logic [2*xlen:0]    dvs_q;
  logic [count_w-1:0] count_q;
  logic               quo_sign_q;
  logic               rem_sign_q;

  logic [2*xlen:0] shifted;
  logic [2*xlen:0] diff;

  assign shifted = rq_q << 1;
  assign diff    = shifted - dvs_q;

  // borrow out of the top bit means the divisor did not fit
  assign sub_neg    = diff[2*xlen];
  assign count_zero = (count_q == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      count_q <= '0;
    end else if (load) begin
      count_q <= count_w'(xlen - 1);
    end else if (step) begin
      count_q <= count_q - 1'b1;
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (load) begin
      rq_q       <= {{(xlen + 1){1'b0}}, a_mag};
      dvs_q      <= {1'b0, b_mag, {xlen{1'b0}}};
      // raw sign bits, masked by the held signed_op in done
      quo_sign_q <= req.a[xlen-1] ^ req.b[xlen-1];
      rem_sign_q <= req.a[xlen-1];
    end else if (step) begin
      // keep the difference and set the quotient bit, or restore
      if (!sub_neg) begin
        rq_q <= {diff[2*xlen:1], 1'b1};
      end else begin
        rq_q <= shifted;
      end
    end
  end

  // ------------------------------------------------------------
  // result with signs applied
  // ------------------------------------------------------------

  logic [xlen-1:0] quo;
  logic [xlen-1:0] rem;

  assign quo = rq_q[xlen-1:0];
  assign rem = rq_q[2*xlen-1:xlen];

  always_comb begin
    result.result[xlen-1:0]      = quo;
    result.result[2*xlen-1:xlen] = rem;
    if (fix_signs && signed_op && quo_sign_q) begin
      result.result[xlen-1:0] = ~quo + 1'b1;
    end
    if (fix_signs && signed_op && rem_sign_q) begin
      result.result[2*xlen-1:xlen] = ~rem + 1'b1;
    end
  end

  // control must never load over a running step
  assert property (@(posedge clk) disable iff (reset) !(load && step));

endmodule

`default_nettype wire

//--- int_div/int_div_iterative.sv
// ------------------------------------------------------------
// iterative divider, response 33 edges after acceptance
// remainder in the upper half, quotient in the lower half
// ------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module int_div_iterative (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_pkg::imuldiv_req_t  req,
  input  logic                       req_val,
  output logic                       req_rdy,
  output imuldiv_pkg::imuldiv_resp_t resp,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  // control to datapath
  logic load;
  logic step;
  logic signed_op;
  logic fix_signs;

  // datapath status
  logic sub_neg;
  logic count_zero;

  int_div_dpath dpath0 (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .result     (resp),
    .load       (load),
    .step       (step),
    .signed_op  (signed_op),
    .fix_signs  (fix_signs),
    .sub_neg    (sub_neg),
    .count_zero (count_zero)
  );

  int_div_ctrl ctrl0 (
    .clk        (clk),
    .reset      (reset),
    .op         (req.op),
    .req_val    (req_val),
    .req_rdy    (req_rdy),
    .resp_val   (resp_val),
    .resp_rdy   (resp_rdy),
    .sub_neg    (sub_neg),
    .count_zero (count_zero),
    .load       (load),
    .step       (step),
    .signed_op  (signed_op),
    .fix_signs  (fix_signs)
  );

endmodule

`default_nettype wire

//--- rtl/imuldiv_unit.sv
// ------------------------------------------------------------
// multiply/divide top, one op in flight per unit
// responses return in request order via a 2-entry order queue
// ------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module imuldiv_unit (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_pkg::imuldiv_req_t  req,
  input  logic                       req_val,
  output logic                       req_rdy,
  output imuldiv_pkg::imuldiv_resp_t resp,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  import imuldiv_pkg::*;

  // ------------------------------------------------------------
  // request steering
  // ------------------------------------------------------------

  logic          to_div;
  logic          div_req_rdy;
  logic          mul_req_rdy;
  imuldiv_resp_t div_resp;
  imuldiv_resp_t mul_resp;
  logic          div_resp_val;
  logic          mul_resp_val;
  logic          head_div;
  logic          q_empty;

  assign to_div  = is_div_op(req.op);
  assign req_rdy = to_div ? div_req_rdy : mul_req_rdy;

  int_div_iterative div0 (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val && to_div),
    .req_rdy  (div_req_rdy),
    .resp     (div_resp),
    .resp_val (div_resp_val),
    .resp_rdy (resp_rdy && head_div && !q_empty)
  );

  int_mul_iterative mul0 (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val && !to_div),
    .req_rdy  (mul_req_rdy),
    .resp     (mul_resp),
    .resp_val (mul_resp_val),
    .resp_rdy (resp_rdy && !head_div && !q_empty)
  );

  // ------------------------------------------------------------
  // order queue, 1 = divider, 0 = multiplier
  // ------------------------------------------------------------

  logic [1:0] q_mem;
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       q_full;
  logic       push;
  logic       pop;

  assign q_empty = (count_q == 2'd0);
  assign q_full  = (count_q == 2'd2);
  assign push    = req_val && req_rdy;
  assign pop     = resp_val && resp_rdy;

  assign head_div = q_mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // push and pop together leave the count alone
      if (push && !pop) begin
        count_q <= count_q + 2'd1;
      end else if (pop && !push) begin
        count_q <= count_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q_mem[wr_ptr_q] <= to_div;
    end
  end

  // ------------------------------------------------------------
  // response mux, head of queue only
  // ------------------------------------------------------------

  assign resp_val = !q_empty && (head_div ? div_resp_val : mul_resp_val);
  assign resp     = head_div ? div_resp : mul_resp;

  // each unit holds at most one op, so two entries always suffice
  assert property (@(posedge clk) disable iff (reset)
    !(push && q_full) && !(pop && q_empty));

endmodule

`default_nettype wire

//--- rtl/int_mul_iterative.sv
// ------------------------------------------------------------
// iterative shift-and-add multiplier, 32 steps, no early exit
// signed ops multiply magnitudes, product negated in done
// ------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module int_mul_iterative (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_pkg::imuldiv_req_t  req,
  input  logic                       req_val,
  output logic                       req_rdy,
  output imuldiv_pkg::imuldiv_resp_t resp,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  import imuldiv_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_e;

  state_e             state_q;
  logic [count_w-1:0] count_q;
  logic               signed_q;

  // payload
  logic [2*xlen-1:0] mcand_q;
  logic [xlen-1:0]   mplier_q;
  logic [2*xlen-1:0] acc_q;
  logic              neg_q;

  // ------------------------------------------------------------
  // operand magnitudes at acceptance
  // ------------------------------------------------------------

  logic            req_signed;
  logic [xlen-1:0] a_mag;
  logic [xlen-1:0] b_mag;

  assign req_signed = is_signed_op(req.op);
  assign a_mag = (req_signed && req.a[xlen-1]) ? (~req.a + 1'b1) : req.a;
  assign b_mag = (req_signed && req.b[xlen-1]) ? (~req.b + 1'b1) : req.b;

  assign req_rdy  = (state_q == st_idle);
  assign resp_val = (state_q == st_done);

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q  <= st_idle;
      count_q  <= '0;
      signed_q <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (req_val) begin
            state_q  <= st_calc;
            count_q  <= count_w'(xlen - 1);
            signed_q <= req_signed;
          end
        end
        st_calc: begin
          count_q <= count_q - 1'b1;
          if (count_q == '0) begin
            state_q <= st_done;
          end
        end
        st_done: begin
          if (resp_rdy) begin
            state_q <= st_idle;
          end
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // shift and add
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req_rdy && req_val) begin
      acc_q    <= '0;
      mcand_q  <= {{xlen{1'b0}}, a_mag};
      mplier_q <= b_mag;
      // raw sign xor, masked by signed_q in done
      neg_q    <= req.a[xlen-1] ^ req.b[xlen-1];
    end else if (state_q == st_calc) begin
      // add the multiplicand when the low multiplier bit is set
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // product sign applied here
  assign resp.result = (signed_q && neg_q) ? (~acc_q + 1'b1) : acc_q;

  // a held response must not change under back-pressure
  assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp));

endmodule

`default_nettype wire

//--- src.f
+incdir+tb
common/imuldiv_pkg.sv
int_div/int_div_dpath.sv
int_div/int_div_ctrl.sv
int_div/int_div_iterative.sv
rtl/int_mul_iterative.sv
rtl/imuldiv_unit.sv
tb/imuldiv_tb.sv

//--- tb/imuldiv_model.svh
// ------------------------------------------------------------
// expected results and the value check, included in imuldiv_tb
// needs the package imported before the include
// ------------------------------------------------------------

`ifndef imuldiv_model_svh
`define imuldiv_model_svh

// full 64-bit product, sign extension picks signed or unsigned
function automatic logic [63:0] product_model(logic [31:0] a, logic [31:0] b, logic sgn);
  logic [63:0] a_ext;
  logic [63:0] b_ext;
  a_ext = sgn ? {{32{a[31]}}, a} : {32'h0, a};
  b_ext = sgn ? {{32{b[31]}}, b} : {32'h0, b};
  return a_ext * b_ext;
endfunction

// remainder in the upper half, quotient in the lower half
function automatic logic [63:0] quotient_model(logic [31:0] a, logic [31:0] b, logic sgn);
  logic [31:0] q;
  logic [31:0] r;
  if (b == 32'h0) begin
    // all ones magnitude takes the sign of a, remainder is a itself
    q = (sgn && a[31]) ? 32'h1 : 32'hffff_ffff;
    r = a;
  end else if (sgn && (a == 32'h8000_0000) && (b == 32'hffff_ffff)) begin
    q = 32'h8000_0000;
    r = 32'h0;
  end else if (sgn) begin
    // truncating division, remainder follows the sign of a
    q = $signed(a) / $signed(b);
    r = $signed(a) % $signed(b);
  end else begin
    q = a / b;
    r = a % b;
  end
  return {r, q};
endfunction

function automatic logic [63:0] expected_result(imuldiv_req_t r);
  case (r.op)
    op_mul:  return product_model(r.a, r.b, 1'b1);
    op_mulu: return product_model(r.a, r.b, 1'b0);
    op_div:  return quotient_model(r.a, r.b, 1'b1);
    default: return quotient_model(r.a, r.b, 1'b0);
  endcase
endfunction

// stops the run at the first mismatch
task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
  if (got !== exp) begin
    $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    $display("SIMULATION FAILED");
    $fatal(1, "value check on %s", name);
  end
endtask

`endif

//--- tb/imuldiv_tb.sv
// ------------------------------------------------------------
// random requests with corner operands, random back-pressure
// all results checked in request order against the model
// ------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module imuldiv_tb;

  import imuldiv_pkg::*;

  localparam int reset_cycles = 10;
  localparam int num_directed = 8;
  localparam int num_latency  = 2;
  localparam int num_random   = 300;
  localparam int total_reqs   = num_directed + num_latency + num_random;

  logic          clk;
  logic          reset;
  imuldiv_req_t  req;
  logic          req_val;
  logic          req_rdy;
  imuldiv_resp_t resp;
  logic          resp_val;
  logic          resp_rdy;

  int            seed;
  int            sink_seed;
  logic          always_ready;
  logic [63:0]   expected_q[$];
  imuldiv_req_t  directed[num_directed];

  `include "imuldiv_model.svh"

  imuldiv_unit dut0 (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------

  function automatic imuldiv_req_t make_req(imuldiv_op_e op, logic [31:0] a, logic [31:0] b);
    imuldiv_req_t r;
    r.op = op;
    r.a  = a;
    r.b  = b;
    return r;
  endfunction

  // corner values show up about half the time
  function automatic logic [31:0] random_operand();
    logic [2:0]  pick;
    logic [31:0] value;
    pick  = $random(seed);
    value = $random(seed);
    case (pick)
      3'd0: value = 32'h0;
      3'd1: value = 32'h1;
      3'd2: value = 32'hffff_ffff;
      3'd3: value = 32'h8000_0000;
      default: ;
    endcase
    return value;
  endfunction

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_request(input imuldiv_req_t r);
    req     = r;
    req_val = 1'b1;
    // rdy at the rising edge still shows the state before that edge
    do begin
      @(posedge clk);
    end while (!req_rdy);
    expected_q.push_back(expected_result(r));
    @(negedge clk);
    req_val = 1'b0;
  endtask

  // lone request, sink always ready, count edges with the accepting edge as 1
  task automatic measure_latency(input imuldiv_req_t r);
    int edges;
    send_request(r);
    edges = 1;
    while (!resp_val && (edges < 100)) begin
      @(negedge clk);
      edges++;
    end
    check_value("resp_val latency", edges, 33);
  endtask

  task automatic wait_drained();
    while (expected_q.size() != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------

  initial begin
    logic [1:0] code;
    imuldiv_req_t r;
    seed         = 32'h19fd_b29b;
    sink_seed    = seed ^ 32'h5a5a_5a5a;
    always_ready = 1'b0;
    reset        = 1'b1;
    req          = '0;
    req_val      = 1'b0;
    resp_rdy     = 1'b0;
    directed[0] = make_req(op_div, 32'h8000_0000, 32'hffff_ffff);
    directed[1] = make_req(op_div, 32'h8000_0000, 32'h0);
    directed[2] = make_req(op_div, 32'hffff_fff9, 32'h2);
    directed[3] = make_req(op_divu, 32'hffff_ffff, 32'h0);
    directed[4] = make_req(op_div, 32'h7, 32'hffff_fffe);
    directed[5] = make_req(op_mul, 32'h8000_0000, 32'h8000_0000);
    directed[6] = make_req(op_mulu, 32'hffff_ffff, 32'hffff_ffff);
    directed[7] = make_req(op_mul, 32'hffff_ffff, 32'h1);

    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_value("resp_val after reset", resp_val, 0);
    check_value("req_rdy after reset", req_rdy, 1);

    // latency of each unit on its own
    always_ready = 1'b1;
    measure_latency(make_req(op_mulu, 32'h1234_5678, 32'h9abc_def0));
    wait_drained();
    measure_latency(make_req(op_div, 32'hdead_beef, 32'h0000_0123));
    wait_drained();
    always_ready = 1'b0;

    foreach (directed[i]) begin
      send_request(directed[i]);
    end

    // mixed ops keep both units busy, gaps between requests are random
    for (int n = 0; n < num_random; n++) begin
      code = $random(seed);
      r    = make_req(imuldiv_op_e'(code), random_operand(), random_operand());
      send_request(r);
      repeat ($random(seed) & 3) @(negedge clk);
    end

    wait_drained();
    check_value("resp_val when drained", resp_val, 0);
    $display("SIMULATION PASSED");
    $finish;
  end

  // ------------------------------------------------------------
  // response sink
  // ------------------------------------------------------------

  initial begin
    logic        held_valid;
    logic [63:0] held_value;
    held_valid = 1'b0;
    held_value = '0;
    forever begin
      @(negedge clk);
      if (!reset) begin
        // a refused response must come back unchanged
        if (held_valid) begin
          check_value("resp_val held", resp_val, 1);
          check_value("resp held", resp.result, held_value);
        end
        resp_rdy   = always_ready || (($random(sink_seed) & 3) != 0);
        held_valid = resp_val && !resp_rdy;
        held_value = resp.result;
        // transfer happens on the coming rising edge
        if (resp_val && resp_rdy) begin
          if (expected_q.size() == 0) begin
            $display("a response arrived with no request outstanding");
            $display("SIMULATION FAILED");
            $fatal(1, "unexpected response");
          end
          check_value("resp.result", resp.result, expected_q.pop_front());
        end
      end
    end
  end

  // ------------------------------------------------------------
  // watchdog
  // ------------------------------------------------------------

  initial begin
    repeat (total_reqs * 80 + reset_cycles) @(posedge clk);
    $display("responses stopped before all requests were answered");
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire
